//--- loader_top.f
logic/loader_pkg.sv
logic/word_bus_if.sv
logic/uart_rx.sv
logic/word_assembler.sv
logic/load_sequencer.sv
logic/prog_ram.sv
logic/hex_display.sv
logic/loader_top.sv
bench/loader_assert.sv
bench/loader_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module loader_tb -f loader_top.f -o loader_sim &&
./obj_dir/loader_sim | tee /dev/stderr | grep -q "Verification passed" &&
echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }

//--- bench/loader_tb.sv
`timescale 1ns/10ps

module loader_tb import loader_pkg::*; ();
    localparam int clks_per_bit = 8;

    logic sysclk;
    logic sysrst;
    logic rx;
    logic load_en;
    addr_t view_addr;
    seg_t hex0, hex1, hex2, hex3, hex4, hex5;
    addr_t load_count;
    logic cpu_run;
    logic [31:0] lfsr;
    word_t words [0:5];
    int checks;
    int errors;

    // Active-low digit codes 0 to F, decimal point off
    seg_t seg_ref [16] = '{8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
                           8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e};

    loader_top #(.clks_per_bit(clks_per_bit)) loader_top_inst (
        .sysclk(sysclk), .sysrst(sysrst), .rx(rx), .load_en(load_en),
        .view_addr(view_addr), .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
        .hex4(hex4), .hex5(hex5), .load_count(load_count), .cpu_run(cpu_run)
    );

    always #5 sysclk = ~sysclk;

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v[i] = lfsr[0];
        end
        return v;
    endfunction

    function automatic logic [47:0] display_of(input word_t w, input addr_t a);
        return {seg_ref[w[15:12]], seg_ref[w[11:8]], seg_ref[w[7:4]], seg_ref[w[3:0]],
                seg_ref[a[7:4]], seg_ref[a[3:0]]};
    endfunction

    // Start bit, 8 data bits LSB first, stop bit, then one idle bit
    task automatic send_byte(input byte_t b, input logic stop);
        logic [9:0] frame;
        frame = {stop, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (clks_per_bit) @(negedge sysclk);
        end
        rx = 1'b1;
        repeat (clks_per_bit) @(negedge sysclk);
    endtask

    task automatic send_word(input word_t w);
        send_byte(w[15:8], 1'b1);
        send_byte(w[7:0], 1'b1);
    endtask

    task automatic wait_count(input addr_t target, input string test);
        int n;
        n = 0;
        while (load_count !== target && n < 200) begin
            @(negedge sysclk);
            n++;
        end
        checks++;
        assert (load_count === target) else begin
            errors++;
            $display("ERR %s load_count expected %0d actual %0d", test, target, load_count);
        end
    endtask

    task automatic check_addr(input addr_t a, input word_t w, input string test);
        logic [47:0] got;
        view_addr = a;
        // Address register, then read register
        repeat (2) @(negedge sysclk);
        got = {hex5, hex4, hex3, hex2, hex1, hex0};
        checks++;
        assert (got === display_of(w, a)) else begin
            errors++;
            $display("ERR %s addr %h expected %h actual %h", test, a, display_of(w, a), got);
        end
    endtask

    task automatic load_words(input int count, input string test);
        logic [15:0] v;
        for (int i = 0; i < count; i++) begin
            v = rand_bits(16);
            words[i] = v;
            send_word(v);
            wait_count(addr_t'(i + 1), test);
        end
    endtask

    task automatic restart_load(input string test);
        load_en = 1'b0;
        repeat (4) @(negedge sysclk);
        load_en = 1'b1;
        wait_count(8'd0, test);
    endtask

    task automatic reset_and_clear();
        int start;
        int n;
        logic [15:0] v;
        start = errors;
        checks++;
        assert (cpu_run === 1'b0) else begin
            errors++;
            $display("ERR reset_clear cpu_run expected 0 actual %b", cpu_run);
        end
        n = 0;
        while (!cpu_run && n < 300) begin
            @(negedge sysclk);
            n++;
        end
        checks++;
        if (!cpu_run) begin
            errors++;
            $display("reset_clear: cpu_run did not rise within 300 cycles");
        end else begin
            for (int i = 0; i < 8; i++) begin
                v = rand_bits(8);
                check_addr(v[7:0], 16'h0000, "reset_clear");
            end
        end
        $display("reset_clear done, %0d errors", errors - start);
    endtask

    task automatic load_and_read_back();
        int start;
        start = errors;
        restart_load("load_read");
        load_words(6, "load_read");
        load_en = 1'b0;
        for (int i = 0; i < 6; i++) check_addr(addr_t'(i), words[i], "load_read");
        $display("load_read done, %0d errors", errors - start);
    endtask

    task automatic reload_from_zero();
        int start;
        start = errors;
        restart_load("reload");
        load_words(3, "reload");
        load_en = 1'b0;
        for (int i = 0; i < 4; i++) check_addr(addr_t'(i), words[i], "reload");
        $display("reload done, %0d errors", errors - start);
    endtask

    task automatic framing_error();
        int start;
        logic [15:0] v;
        start = errors;
        restart_load("framing");
        v = rand_bits(8);
        send_byte(v[7:0], 1'b0);
        load_words(1, "framing");
        load_en = 1'b0;
        check_addr(8'd0, words[0], "framing");
        $display("framing done, %0d errors", errors - start);
    endtask

    task automatic idle_reads();
        int start;
        logic [15:0] v;
        start = errors;
        v = rand_bits(16);
        send_word(v);
        wait_count(8'd1, "idle");
        for (int i = 0; i < 4; i++) check_addr(addr_t'(i), words[i], "idle");
        $display("idle done, %0d errors", errors - start);
    endtask

    initial begin
        sysclk = 1'b0;
        sysrst = 1'b0;
        rx = 1'b1;
        load_en = 1'b0;
        view_addr = '0;
        lfsr = 32'hf636;
        checks = 0;
        errors = 0;
        repeat (10) @(negedge sysclk);
        sysrst = 1'b1;
        reset_and_clear();
        load_and_read_back();
        reload_from_zero();
        framing_error();
        idle_reads();
        $display("Tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- bench/loader_assert.sv
`timescale 1ns/10ps

module loader_assert (
    input logic sysclk,
    input logic sysrst,
    input logic cpu_run,
    input logic load_en,
    input logic word_valid,
    input logic wr_en,
    input logic clear
);
    // No memory write before the subsystem runs
    a_wr_needs_run: assert property (@(posedge sysclk) disable iff (!sysrst)
        wr_en |-> cpu_run)
        else $error("wr_en high while cpu_run is low");

    a_wr_follows_word: assert property (@(posedge sysclk) disable iff (!sysrst)
        (word_valid && cpu_run && load_en) |=> wr_en)
        else $error("wr_en missing one cycle after word_valid");

    a_clear_pulse: assert property (@(posedge sysclk) disable iff (!sysrst)
        clear |=> !clear)
        else $error("clear held longer than one cycle");

endmodule

bind load_sequencer loader_assert loader_assert_inst (
    .sysclk(sysclk),
    .sysrst(sysrst),
    .cpu_run(cpu_run),
    .load_en(load_en),
    .word_valid(bus.word_valid),
    .wr_en(bus.wr_en),
    .clear(clear)
);

//--- logic/loader_top.sv
`timescale 1ns/10ps

module loader_top import loader_pkg::*; #(
    parameter int clks_per_bit = 8
) (
    input  logic  sysclk,
    input  logic  sysrst,
    input  logic  rx,
    input  logic  load_en,
    input  addr_t view_addr,
    output seg_t  hex0,
    output seg_t  hex1,
    output seg_t  hex2,
    output seg_t  hex3,
    output seg_t  hex4,
    output seg_t  hex5,
    output addr_t load_count,
    output logic  cpu_run
);
    logic  byte_valid;
    byte_t rx_byte;
    logic  clear;
    logic  mem_ready;
    addr_t rd_addr;
    word_t rd_data;

    word_bus_if word_bus ();

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) uart_rx_inst (
        .sysclk(sysclk),
        .sysrst(sysrst),
        .rx(rx),
        .byte_valid(byte_valid),
        .rx_byte(rx_byte)
    );

    word_assembler word_assembler_inst (
        .sysclk(sysclk),
        .sysrst(sysrst),
        .clear(clear),
        .byte_valid(byte_valid),
        .rx_byte(rx_byte),
        .bus(word_bus.asm)
    );

    load_sequencer load_sequencer_inst (
        .sysclk(sysclk),
        .sysrst(sysrst),
        .load_en(load_en),
        .view_addr(view_addr),
        .mem_ready(mem_ready),
        .bus(word_bus.seq),
        .rd_addr(rd_addr),
        .clear(clear),
        .load_count(load_count),
        .cpu_run(cpu_run)
    );

    prog_ram prog_ram_inst (
        .sysclk(sysclk),
        .sysrst(sysrst),
        .bus(word_bus.ram),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .mem_ready(mem_ready)
    );

    // Word on the left four digits, address on the right two
    hex_display hex_display_inst (
        .value({rd_data, rd_addr}),
        .hex({hex5, hex4, hex3, hex2, hex1, hex0})
    );

endmodule

//--- logic/hex_display.sv
`timescale 1ns/10ps

module hex_display import loader_pkg::*; (
    input  logic [23:0]     value,
    output seg_t [5:0]      hex
);
    function automatic seg_t seg_of(input logic [3:0] nib);
        seg_t seg;
        case (nib)
            4'h0: seg = 8'hc0;
            4'h1: seg = 8'hf9;
            4'h2: seg = 8'ha4;
            4'h3: seg = 8'hb0;
            4'h4: seg = 8'h99;
            4'h5: seg = 8'h92;
            4'h6: seg = 8'h82;
            4'h7: seg = 8'hf8;
            4'h8: seg = 8'h80;
            4'h9: seg = 8'h90;
            4'ha: seg = 8'h88;
            4'hb: seg = 8'h83;
            4'hc: seg = 8'hc6;
            4'hd: seg = 8'ha1;
            4'he: seg = 8'h86;
            default: seg = 8'h8e;
        endcase
        return seg;
    endfunction

    // Digit 0 is the lowest nibble
    for (genvar i = 0; i < 6; i++) begin : g_digit
        assign hex[i] = seg_of(value[i*4 +: 4]);
    end

endmodule

//--- logic/prog_ram.sv
`timescale 1ns/10ps

module prog_ram import loader_pkg::*; (
    input  logic    sysclk,
    input  logic    sysrst,
    word_bus_if.ram bus,
    input  addr_t   rd_addr,
    output word_t   rd_data,
    output logic    mem_ready
);
    localparam int depth = 2 ** addr_width;

    word_t mem [0:depth-1];
    addr_t sweep_addr;

    // Clear sweep covers every entry once
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            sweep_addr <= '0;
            mem_ready  <= 1'b0;
        end else if (!mem_ready) begin
            sweep_addr <= sweep_addr + 1'b1;
            if (sweep_addr == '1) begin
                mem_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (!mem_ready) begin
            mem[sweep_addr] <= '0;
        end else if (bus.wr_en) begin
            mem[bus.wr_addr] <= bus.word;
        end
    end

    // One cycle read latency
    always_ff @(posedge sysclk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- logic/load_sequencer.sv
`timescale 1ns/10ps

module load_sequencer import loader_pkg::*; (
    input  logic    sysclk,
    input  logic    sysrst,
    input  logic    load_en,
    input  addr_t   view_addr,
    input  logic    mem_ready,
    word_bus_if.seq bus,
    output addr_t   rd_addr,
    output logic    clear,
    output addr_t   load_count,
    output logic    cpu_run
);
    seq_state_t state;
    logic [1:0] load_en_q;
    logic       load_rise;

    assign cpu_run   = (state == seq_running);
    assign load_rise = load_en_q[0] & ~load_en_q[1];

    // Next word always lands at the running count
    assign bus.wr_addr = load_count;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            state <= seq_reset;
        end else begin
            case (state)
                seq_reset: begin
                    if (mem_ready) state <= seq_running;
                end
                seq_running: state <= seq_running;
                default: state <= seq_reset;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            load_en_q  <= 2'b11;
            clear      <= 1'b0;
            bus.wr_en  <= 1'b0;
            load_count <= '0;
            rd_addr    <= '0;
        end else begin
            load_en_q <= {load_en_q[0], load_en};
            clear     <= load_rise;
            bus.wr_en <= bus.word_valid && cpu_run && mem_ready && load_en;

            if (clear) begin
                load_count <= '0;
            end else if (bus.wr_en) begin
                load_count <= load_count + 1'b1;
            end

            rd_addr <= load_en ? load_count : view_addr;
        end
    end

endmodule

//--- logic/word_assembler.sv
`timescale 1ns/10ps

module word_assembler import loader_pkg::*; (
    input  logic    sysclk,
    input  logic    sysrst,
    input  logic    clear,
    input  logic    byte_valid,
    input  byte_t   rx_byte,
    word_bus_if.asm bus
);
    // High when the high byte is already held
    logic  phase;
    byte_t high_byte;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            phase          <= 1'b0;
            bus.word_valid <= 1'b0;
        end else begin
            bus.word_valid <= 1'b0;
            if (clear) begin
                phase <= 1'b0;
            end else if (byte_valid) begin
                phase          <= ~phase;
                bus.word_valid <= phase;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (byte_valid && !phase) begin
            high_byte <= rx_byte;
        end
        if (byte_valid && phase && !clear) begin
            bus.word <= {high_byte, rx_byte};
        end
    end

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/10ps

module uart_rx import loader_pkg::*; #(
    parameter int clks_per_bit = 8
) (
    input  logic  sysclk,
    input  logic  sysrst,
    input  logic  rx,
    output logic  byte_valid,
    output byte_t rx_byte
);
    localparam int half_bit = clks_per_bit / 2;
    localparam int cnt_w = $clog2(clks_per_bit + 1);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t state;
    logic [1:0] rx_sync;
    logic [cnt_w-1:0] clk_cnt;
    logic [2:0] bit_idx;
    byte_t shift_reg;

    wire rx_s = rx_sync[1];

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            rx_sync    <= 2'b11;
            state      <= rx_idle;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[0], rx};
            byte_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    clk_cnt <= '0;
                    if (!rx_s) state <= rx_start;
                end
                rx_start: begin
                    // Confirm start bit at its middle
                    if (clk_cnt == cnt_w'(half_bit - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? rx_idle : rx_data;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= rx_stop;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
                        state <= rx_idle;
                        // Framing error drops the byte
                        byte_valid <= rx_s;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge sysclk) begin
        if (state == rx_data && clk_cnt == cnt_w'(clks_per_bit - 1)) begin
            shift_reg <= {rx_s, shift_reg[7:1]};
        end
        if (state == rx_stop && clk_cnt == cnt_w'(clks_per_bit - 1)) begin
            rx_byte <= shift_reg;
        end
    end

endmodule

//--- logic/word_bus_if.sv
`timescale 1ns/10ps

interface word_bus_if import loader_pkg::*; ();

    // Assembled word and its one-cycle strobe
    logic  word_valid;
    word_t word;

    // Memory write request from the load sequencer
    logic  wr_en;
    addr_t wr_addr;

    modport asm (
        output word_valid,
        output word
    );

    modport seq (
        input  word_valid,
        input  word,
        output wr_en,
        output wr_addr
    );

    modport ram (
        input  wr_en,
        input  wr_addr,
        input  word
    );

endinterface

//--- logic/loader_pkg.sv
package loader_pkg;

    // Program memory depth is 2**addr_width words
    localparam int addr_width = 8;

    typedef logic [15:0] word_t;
    typedef logic [7:0] byte_t;
    typedef logic [addr_width-1:0] addr_t;

    // Active low, decimal point in bit 7
    typedef logic [7:0] seg_t;

    // Subsystem held in reset until program memory is cleared
    typedef enum logic {
        seq_reset,
        seq_running
    } seq_state_t;

endpackage
